// ==== Bender.yml ====
package:
  name: log_compare_unit

sources:
  - logNumberPkg.sv
  - logUnpack.sv
  - logCompare.sv
  - logSelect.sv
  - logCompareUnit.sv
  - target: test
    files:
      - logCompareUnit_checker.sv
      - tbLogCompareUnit.sv

// ==== logCompare.sv ====
// combinational ordering of two unpacked log numbers
// produces eq/lt/gt flags and the predicate bit selected by comp
`timescale 1ns/1ps
`default_nettype none

module logCompare (
  input  logNumberPkg::logUnpacked_t  a,
  input  logNumberPkg::logUnpacked_t  b,
  input  logNumberPkg::Comparison_t   comp,
  output logNumberPkg::compareFlags_t flags,
  output logic                        predicate
);

  import logNumberPkg::*;

  logExp_t aExp;
  logExp_t bExp;
  logic    aIsNeg;
  logic    bIsNeg;
  logic    expLt;
  logic    expEq;
  logic    fracLt;
  logic    fracGt;
  logic    magLt;
  logic    magGt;
  logic    bothFinite;
  logic    abEq;
  logic    abLt;
  logic    abGt;

  // signed exponent compare, larger exponent means larger magnitude
  assign aExp   = a.signedLogExp;
  assign bExp   = b.signedLogExp;
  assign expLt  = (aExp < bExp);
  assign expEq  = (aExp == bExp);
  assign fracLt = (a.logFrac < b.logFrac);
  assign fracGt = (a.logFrac > b.logFrac);

  // zero has a cleared sign so it lands among the non-negatives
  assign aIsNeg = a.sign;
  assign bIsNeg = b.sign;

  // magnitude ordering with zero below every nonzero value
  assign magLt = (a.isZero && !b.isZero) ||
                 (!a.isZero && !b.isZero && (expLt || (expEq && fracLt)));
  assign magGt = (!a.isZero && b.isZero) ||
                 (!a.isZero && !b.isZero && (!expLt && !expEq || (expEq && fracGt)));

  // unpacked specials are canonical, so plain bit equality is enough
  assign abEq = (a == b);

  // infinity is unordered against everything
  assign bothFinite = !a.isInf && !b.isInf;

  // negatives order by reversed magnitude
  assign abLt = bothFinite &&
                ((aIsNeg && !bIsNeg) ||
                 (!aIsNeg && !bIsNeg && magLt) ||
                 (aIsNeg && bIsNeg && magGt));

  assign abGt = bothFinite &&
                ((!aIsNeg && bIsNeg) ||
                 (!aIsNeg && !bIsNeg && magGt) ||
                 (aIsNeg && bIsNeg && magLt));

  assign flags.eq = abEq;
  assign flags.lt = abLt;
  assign flags.gt = abGt;

  always_comb begin
    case (comp)
      NE:      predicate = !abEq;
      LT:      predicate = abLt;
      // eq term lets inf <= inf hold
      LE:      predicate = abLt || abEq;
      GT:      predicate = abGt;
      GE:      predicate = abGt || abEq;
      default: predicate = abEq;
    endcase
  end

endmodule

`default_nettype wire

// ==== logCompareUnit.sv ====
// top level of the log number comparison unit
// one item per cycle in, result and outValid exactly one cycle later
`timescale 1ns/1ps
`default_nettype none

module logCompareUnit (
  input  logic                         clock,
  input  logic                         reset,
  input  logic                         inValid,
  input  logNumberPkg::logWord_t       aWord,
  input  logNumberPkg::logWord_t       bWord,
  input  logNumberPkg::Comparison_t    comp,
  output logic                         outValid,
  output logNumberPkg::compareResult_t result
);

  import logNumberPkg::*;

  logUnpacked_t  aUnpacked;
  logUnpacked_t  bUnpacked;
  compareFlags_t flags;
  logic          predicate;

  logUnpack u_unpackA (
    .word     (aWord),
    .unpacked (aUnpacked)
  );

  logUnpack u_unpackB (
    .word     (bWord),
    .unpacked (bUnpacked)
  );

  // same cycle as the inputs
  logCompare u_compare (
    .a         (aUnpacked),
    .b         (bUnpacked),
    .comp      (comp),
    .flags     (flags),
    .predicate (predicate)
  );

  // the single register stage
  logSelect u_select (
    .clock     (clock),
    .reset     (reset),
    .inValid   (inValid),
    .aWord     (aWord),
    .bWord     (bWord),
    .flags     (flags),
    .predicate (predicate),
    .outValid  (outValid),
    .result    (result)
  );

endmodule

`default_nettype wire

// ==== logCompareUnit_checker.sv ====
// assertions bound into logCompareUnit by the testbench
// cover outValid timing around reset and the order of the min and max words
`timescale 1ns/1ps
`default_nettype none

module logCompareUnit_checker (
  input logic                         clock,
  input logic                         reset,
  input logic                         inValid,
  input logic                         outValid,
  input logNumberPkg::compareResult_t result
);

  import logNumberPkg::*;

  logic minNeg;
  logic maxNeg;
  logic minInf;
  logic maxInf;

  // number of failed assertions
  int failCount = 0;

  assign minNeg = result.minWord[LogSignBit];
  assign maxNeg = result.maxWord[LogSignBit];
  assign minInf = (result.minWord == InfWord);
  assign maxInf = (result.maxWord == InfWord);

  // one cycle latency with no item created or dropped
  validFollowsInput: assert property (
    @(posedge clock) disable iff (reset)
      !$past(reset) |-> (outValid == $past(inValid))
  ) else begin
    failCount++;
    $error("outValid differs from inValid one cycle earlier");
  end

  // the register comes out of reset empty
  validLowAfterReset: assert property (
    @(posedge clock) $past(reset) |-> !outValid
  ) else begin
    failCount++;
    $error("outValid is high in the cycle after reset");
  end

  // a non-negative minimum above a negative maximum is out of order
  minNotAboveMax: assert property (
    @(posedge clock) disable iff (reset)
      outValid |-> !(!minNeg && maxNeg)
  ) else begin
    failCount++;
    $error("minWord is ordered above maxWord");
  end

  // infinity shows up in both words or in neither
  infinityInBoth: assert property (
    @(posedge clock) disable iff (reset)
      outValid |-> (minInf == maxInf)
  ) else begin
    failCount++;
    $error("infinity appears in only one of minWord and maxWord");
  end

endmodule

`default_nettype wire

// ==== logNumberPkg.sv ====
// shared widths, reserved encodings and types for the log number comparison unit
// a value is (-1)^sign * 2^(signedLogExp + logFrac/16)
// RTL modules import it by wildcard inside the body, headers use scoped names
`default_nettype none

package logNumberPkg;

  // field widths of a packed log word
  localparam int LogExpWidth  = 4;
  localparam int LogFracWidth = 4;
  localparam int LogWordWidth = 1 + LogExpWidth + LogFracWidth;

  // field positions inside a packed word, sign on top, fraction at the bottom
  localparam int LogSignBit = LogWordWidth - 1;
  localparam int LogExpLsb  = LogFracWidth;

  // signed exponent and unsigned fraction
  typedef logic signed [LogExpWidth-1:0] logExp_t;
  typedef logic [LogFracWidth-1:0] logFrac_t;

  // packed encoding of one log number
  typedef logic [LogWordWidth-1:0] logWord_t;

  // most negative exponent, reserved for zero and infinity
  localparam logExp_t SpecialExp = {1'b1, {(LogExpWidth-1){1'b0}}};

  // the two reserved words
  // any other word carrying SpecialExp is an ordinary number
  localparam logWord_t ZeroWord = {1'b0, SpecialExp, {LogFracWidth{1'b0}}};
  localparam logWord_t InfWord  = {1'b1, SpecialExp, {LogFracWidth{1'b0}}};

  // decoded form of a word
  // zero and infinity have sign, exponent and fraction cleared
  typedef struct packed {
    logic     sign;
    logic     isZero;
    logic     isInf;
    logExp_t  signedLogExp;
    logFrac_t logFrac;
  } logUnpacked_t;

  // requested predicate
  typedef enum logic [2:0] {
    EQ = 3'd0,
    NE = 3'd1,
    LT = 3'd2,
    LE = 3'd3,
    GT = 3'd4,
    GE = 3'd5
  } Comparison_t;

  // raw ordering of a against b
  // lt and gt are both low when an infinity takes part
  typedef struct packed {
    logic eq;
    logic lt;
    logic gt;
  } compareFlags_t;

  // registered output of the unit
  typedef struct packed {
    logic     predicate;
    logWord_t minWord;
    logWord_t maxWord;
  } compareResult_t;

endpackage

`default_nettype wire

// ==== logSelect.sv ====
// output stage of the comparison unit
// picks the minimum and maximum word from the flags and registers them
// together with the predicate, one cycle after inValid
`timescale 1ns/1ps
`default_nettype none

module logSelect (
  input  logic                         clock,
  input  logic                         reset,
  input  logic                         inValid,
  input  logNumberPkg::logWord_t       aWord,
  input  logNumberPkg::logWord_t       bWord,
  input  logNumberPkg::compareFlags_t  flags,
  input  logic                         predicate,
  output logic                         outValid,
  output logNumberPkg::compareResult_t result
);

  import logNumberPkg::*;

  logWord_t minWordNext;
  logWord_t maxWordNext;
  logic     unordered;

  // no relation at all means an infinity is present
  assign unordered = !flags.eq && !flags.lt && !flags.gt;

  always_comb begin
    if (unordered) begin
      minWordNext = InfWord;
      maxWordNext = InfWord;
    end else if (flags.eq) begin
      minWordNext = aWord;
      maxWordNext = aWord;
    end else if (flags.lt) begin
      minWordNext = aWord;
      maxWordNext = bWord;
    end else begin
      minWordNext = bWord;
      maxWordNext = aWord;
    end
  end

  // valid strobe
  always_ff @(posedge clock) begin
    if (reset) begin
      outValid <= 1'b0;
    end else begin
      outValid <= inValid;
    end
  end

  // payload, held while no new item arrives
  always_ff @(posedge clock) begin
    if (inValid) begin
      result.predicate <= predicate;
      result.minWord   <= minWordNext;
      result.maxWord   <= maxWordNext;
    end
  end

endmodule

`default_nettype wire

// ==== logUnpack.sv ====
// splits a packed log word into its fields and flags zero and infinity
// purely combinational, one instance per operand
`timescale 1ns/1ps
`default_nettype none

module logUnpack (
  input  logNumberPkg::logWord_t     word,
  output logNumberPkg::logUnpacked_t unpacked
);

  import logNumberPkg::*;

  logic     wordSign;
  logExp_t  wordExp;
  logFrac_t wordFrac;
  logic     isZeroWord;
  logic     isInfWord;

  // raw fields
  assign wordSign = word[LogSignBit];
  assign wordExp  = word[LogExpLsb +: LogExpWidth];
  assign wordFrac = word[LogFracWidth-1:0];

  // only the exact reserved patterns are special
  // SpecialExp with a nonzero fraction is a normal tiny number
  assign isZeroWord = (word == ZeroWord);
  assign isInfWord  = (word == InfWord);

  always_comb begin
    unpacked        = '0;
    unpacked.isZero = isZeroWord;
    unpacked.isInf  = isInfWord;

    // specials keep all value fields at zero
    // so every zero and every infinity compare equal bit for bit
    if (!isZeroWord && !isInfWord) begin
      unpacked.sign         = wordSign;
      unpacked.signedLogExp = wordExp;
      unpacked.logFrac      = wordFrac;
    end
  end

endmodule

`default_nettype wire

// ==== src.f ====
logNumberPkg.sv
logUnpack.sv
logCompare.sv
logSelect.sv
logCompareUnit.sv
logCompareUnit_checker.sv
tbLogCompareUnit.sv

// ==== tbLogCompareUnit.sv ====
// directed testbench for the log number comparison unit
// drives word pairs on the falling clock edge and checks every result one cycle later
// against a reference model built on an integer ordering key
`timescale 1ns/1ps
`default_nettype none

module tbLogCompareUnit;

  import logNumberPkg::*;

  localparam int ClockPeriod  = 8;
  localparam int ResetCycles  = 10;
  // reset cycles plus the items of all directed tests
  localparam int ItemCount    = ResetCycles + 8 + 200 + 36 + 6 + 24;
  localparam int MarginCycles = 300;
  localparam int WatchdogTime = (ItemCount + MarginCycles) * ClockPeriod;

  logic           clock = 1'b0;
  logic           reset;
  logic           inValid;
  logWord_t       aWord;
  logWord_t       bWord;
  Comparison_t    comp;
  logic           outValid;
  compareResult_t result;

  integer seed            = 28064;
  int     cycleCount      = 0;
  logic   resetAtLastEdge = 1'b1;
  string  testName        = "none";
  int     errorCount      = 0;
  int     testCount       = 0;
  int     itemCount       = 0;
  int     errorStart      = 0;
  int     itemStart       = 0;

  // expected results in issue order and the cycle each item was driven in
  compareResult_t expectedQueue[$];
  int             stampQueue[$];

  // last expected result that came out, the register must keep it while idle
  compareResult_t heldResult;
  logic           heldResultSeen = 1'b0;

  logCompareUnit u_logCompareUnit (
    .clock    (clock),
    .reset    (reset),
    .inValid  (inValid),
    .aWord    (aWord),
    .bWord    (bWord),
    .comp     (comp),
    .outValid (outValid),
    .result   (result)
  );

  bind logCompareUnit logCompareUnit_checker u_checker (
    .clock    (clock),
    .reset    (reset),
    .inValid  (inValid),
    .outValid (outValid),
    .result   (result)
  );

  always #(ClockPeriod / 2) clock = ~clock;

  always @(posedge clock) begin
    cycleCount      <= cycleCount + 1;
    resetAtLastEdge <= reset;
  end

  // positives map above zero and negatives mirror them below it
  function automatic int orderKey(logWord_t word);
    logExp_t exponent;
    int      magnitude;
    if (word == ZeroWord) begin
      return 0;
    end
    exponent  = word[LogExpLsb +: LogExpWidth];
    magnitude = int'(exponent) * (2 ** LogFracWidth) + int'(word[LogFracWidth-1:0]);
    if (word[LogWordWidth-1]) begin
      return -(magnitude + 129);
    end
    return magnitude + 129;
  endfunction

  function automatic compareResult_t referenceResult(logWord_t a, logWord_t b,
                                                     Comparison_t op);
    compareResult_t expected;
    logic           isEqual;
    logic           isLess;
    logic           isGreater;
    // infinity only relates to itself, and only through equality
    if (a == InfWord || b == InfWord) begin
      isEqual   = (a == b);
      isLess    = 1'b0;
      isGreater = 1'b0;
    end else begin
      isEqual   = (orderKey(a) == orderKey(b));
      isLess    = (orderKey(a) < orderKey(b));
      isGreater = (orderKey(a) > orderKey(b));
    end
    case (op)
      EQ:      expected.predicate = isEqual;
      NE:      expected.predicate = !isEqual;
      LT:      expected.predicate = isLess;
      LE:      expected.predicate = isLess || isEqual;
      GT:      expected.predicate = isGreater;
      GE:      expected.predicate = isGreater || isEqual;
      default: expected.predicate = 1'bx;
    endcase
    if (!isEqual && !isLess && !isGreater) begin
      expected.minWord = InfWord;
      expected.maxWord = InfWord;
    end else if (isEqual) begin
      expected.minWord = a;
      expected.maxWord = a;
    end else if (isLess) begin
      expected.minWord = a;
      expected.maxWord = b;
    end else begin
      expected.minWord = b;
      expected.maxWord = a;
    end
    return expected;
  endfunction

  function automatic int randomBelow(int limit);
    int value;
    value = $random(seed);
    return (value & 32'h7fff_ffff) % limit;
  endfunction

  function automatic logWord_t randomWord();
    int value;
    value = $random(seed);
    return value[LogWordWidth-1:0];
  endfunction

  // roughly one word in eight is forced to zero and infinity is never produced
  function automatic logWord_t randomFiniteWord();
    logWord_t word;
    word = randomWord();
    if (word == InfWord || randomBelow(8) == 0) begin
      word = ZeroWord;
    end
    return word;
  endfunction

  task automatic checkLogic(string what, logic expected, logic actual);
    if (actual !== expected) begin
      errorCount++;
      $display("CHECK FAILED %s %s: expected %b, actual %b",
               testName, what, expected, actual);
    end
  endtask

  task automatic checkWord(string what, logWord_t expected, logWord_t actual);
    if (actual !== expected) begin
      errorCount++;
      $display("CHECK FAILED %s %s: expected %03h, actual %03h",
               testName, what, expected, actual);
    end
  endtask

  // each result must show up exactly one cycle after its item was driven
  always @(negedge clock) begin : resultMonitor
    compareResult_t expected;
    if (!resetAtLastEdge) begin
      if (outValid === 1'b1) begin
        if (stampQueue.size() == 0 || stampQueue[0] != cycleCount - 1) begin
          errorCount++;
          $display("ERROR %s: outValid is high but no item was driven one cycle before",
                   testName);
        end else begin
          expected = expectedQueue.pop_front();
          void'(stampQueue.pop_front());
          checkLogic("predicate", expected.predicate, result.predicate);
          checkWord("minWord", expected.minWord, result.minWord);
          checkWord("maxWord", expected.maxWord, result.maxWord);
          heldResult     = expected;
          heldResultSeen = 1'b1;
        end
      end else if (outValid !== 1'b0) begin
        errorCount++;
        $display("ERROR %s: outValid is unknown", testName);
      end else begin
        if (stampQueue.size() > 0 && stampQueue[0] == cycleCount - 1) begin
          errorCount++;
          $display("ERROR %s: outValid stayed low one cycle after an item", testName);
          void'(expectedQueue.pop_front());
          void'(stampQueue.pop_front());
        end
        // in an idle cycle the register keeps the last result
        if (heldResultSeen) begin
          checkLogic("held predicate", heldResult.predicate, result.predicate);
          checkWord("held minWord", heldResult.minWord, result.minWord);
          checkWord("held maxWord", heldResult.maxWord, result.maxWord);
        end
      end
    end
  end

  task automatic driveItem(logWord_t a, logWord_t b, Comparison_t op);
    @(negedge clock);
    aWord   = a;
    bWord   = b;
    comp    = op;
    inValid = 1'b1;
    expectedQueue.push_back(referenceResult(a, b, op));
    stampQueue.push_back(cycleCount);
    itemCount++;
  endtask

  // junk on the words while idle so a register that fails to hold shows up
  task automatic idleCycles(int count);
    repeat (count) begin
      @(negedge clock);
      inValid = 1'b0;
      aWord   = randomWord();
      bWord   = randomWord();
    end
  endtask

  task automatic startTest(string name);
    testName   = name;
    errorStart = errorCount;
    itemStart  = itemCount;
  endtask

  task automatic finishTest();
    int waited;
    waited = 0;
    idleCycles(1);
    while (stampQueue.size() > 0 && waited < 4) begin
      idleCycles(1);
      waited++;
    end
    if (stampQueue.size() > 0) begin
      errorCount++;
      $display("ERROR %s: %0d results never arrived", testName, stampQueue.size());
      expectedQueue.delete();
      stampQueue.delete();
    end
    testCount++;
    $display("test %s finished: %0d items, %0d errors",
             testName, itemCount - itemStart, errorCount - errorStart);
  endtask

  task automatic resetTest();
    startTest("reset");
    reset = 1'b1;
    for (int i = 0; i < ResetCycles; i++) begin
      @(negedge clock);
      if (outValid !== 1'b0) begin
        errorCount++;
        $display("ERROR %s: outValid is not low during reset", testName);
      end
      // items offered during reset must not come out
      inValid = (i < ResetCycles - 2);
      aWord   = randomWord();
      bWord   = randomWord();
    end
    reset = 1'b0;
    finishTest();
  endtask

  task automatic equalityTest();
    startTest("equality");
    driveItem(9'h05A, 9'h05A, EQ);
    driveItem(9'h05A, 9'h05A, NE);
    driveItem(9'h05A, 9'h13C, EQ);
    driveItem(9'h05A, 9'h13C, NE);
    driveItem(ZeroWord, ZeroWord, EQ);
    driveItem(ZeroWord, ZeroWord, NE);
    driveItem(InfWord, InfWord, EQ);
    driveItem(InfWord, InfWord, NE);
    finishTest();
  endtask

  task automatic orderingTest();
    logWord_t a;
    logWord_t b;
    startTest("ordering");
    for (int i = 0; i < 200; i++) begin
      a = randomFiniteWord();
      b = (randomBelow(8) == 0) ? a : randomFiniteWord();
      driveItem(a, b, Comparison_t'(int'(LT) + randomBelow(4)));
    end
    finishTest();
  endtask

  task automatic infinityTest();
    logWord_t finiteWords[4];
    finiteWords = '{ZeroWord, 9'h0A5, 9'h1A5, 9'h081};
    startTest("infinity");
    for (int c = int'(LT); c <= int'(GE); c++) begin
      for (int k = 0; k < 4; k++) begin
        driveItem(InfWord, finiteWords[k], Comparison_t'(c));
        driveItem(finiteWords[k], InfWord, Comparison_t'(c));
      end
      driveItem(InfWord, InfWord, Comparison_t'(c));
    end
    finishTest();
  endtask

  task automatic minMaxTest();
    startTest("minmax");
    driveItem(9'h023, 9'h045, LT);
    driveItem(9'h045, 9'h023, GE);
    // with both negative the larger magnitude is the minimum
    driveItem(9'h123, 9'h145, GT);
    driveItem(ZeroWord, 9'h145, LE);
    driveItem(9'h037, 9'h037, EQ);
    driveItem(9'h037, InfWord, NE);
    finishTest();
  endtask

  task automatic streamTest();
    startTest("streams");
    for (int i = 0; i < 16; i++) begin
      driveItem(randomWord(), randomWord(), Comparison_t'(randomBelow(6)));
    end
    for (int i = 0; i < 8; i++) begin
      driveItem(randomWord(), randomWord(), Comparison_t'(randomBelow(6)));
      idleCycles(randomBelow(4));
    end
    finishTest();
  endtask

  initial begin
    reset   = 1'b1;
    inValid = 1'b0;
    aWord   = '0;
    bWord   = '0;
    comp    = EQ;
    resetTest();
    equalityTest();
    orderingTest();
    infinityTest();
    minMaxTest();
    streamTest();
    errorCount = errorCount + u_logCompareUnit.u_checker.failCount;
    $display("summary: %0d tests, %0d items, %0d errors", testCount, itemCount, errorCount);
    if (errorCount == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

  initial begin
    #(WatchdogTime);
    $display("watchdog: the run did not finish within %0d ns", WatchdogTime);
    $display("*** FAILED ***");
    $finish;
  end

endmodule

`default_nettype wire
